// ==== exec_pkg.sv ====
// shared widths, rv64i opcode and funct3 codes, and the structs passed between core blocks
`default_nettype none

package exec_pkg;

	localparam int xlen = 64;
	localparam logic [63:0] reset_pc = 64'h0;
	localparam int dmem_words = 64; // doublewords
	localparam int dmem_aw = 6;

	// major opcodes
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm_32 = 7'b0011011;
	localparam logic [6:0] op_reg_32 = 7'b0111011;

	// branch kinds
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_blt = 3'b100;
	localparam logic [2:0] f3_bge = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// load and store sizes, unsigned loads set bit 2
	localparam logic [2:0] f3_byte = 3'b000;
	localparam logic [2:0] f3_half = 3'b001;
	localparam logic [2:0] f3_word = 3'b010;
	localparam logic [2:0] f3_dword = 3'b011;
	localparam logic [2:0] f3_bu = 3'b100;
	localparam logic [2:0] f3_hu = 3'b101;
	localparam logic [2:0] f3_wu = 3'b110;

	// alu function, same code as funct3 of op/op-imm
	typedef logic [2:0] alu_sel_t;
	localparam alu_sel_t alu_add = 3'b000; // add or sub
	localparam alu_sel_t alu_sll = 3'b001;
	localparam alu_sel_t alu_slt = 3'b010;
	localparam alu_sel_t alu_sltu = 3'b011;
	localparam alu_sel_t alu_xor = 3'b100;
	localparam alu_sel_t alu_srl = 3'b101; // srl or sra
	localparam alu_sel_t alu_or = 3'b110;
	localparam alu_sel_t alu_and = 3'b111;

	typedef struct packed {
		logic [6:0] opcode;
		logic [2:0] funct3;
		logic alt; // funct7 bit 5, sub and sra
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [xlen-1:0] imm;
	} decoded_t;

	typedef struct packed {
		logic equal;
		logic smaller_s;
		logic smaller_u;
	} alu_flags_t;

	typedef struct packed {
		logic rd_wen;
		logic [4:0] rd;
		logic [xlen-1:0] x_rd;
		logic [xlen-1:0] dnpc;
	} commit_t;

endpackage

`default_nettype wire

// ==== idu.sv ====
// instruction decoder, slices the fields and builds the sign-extended immediate by format
`timescale 1ns/1ps
`default_nettype none

module idu (
	input wire [31:0] inst,
	output exec_pkg::decoded_t dec
);

	logic [63:0] imm_i;
	logic [63:0] imm_s;
	logic [63:0] imm_b;
	logic [63:0] imm_u;
	logic [63:0] imm_j;

	assign imm_i = {{52{inst[31]}}, inst[31:20]};
	assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec.opcode = inst[6:0];
		dec.funct3 = inst[14:12];
		dec.alt = inst[30];
		dec.rd = inst[11:7];
		dec.rs1 = inst[19:15];
		dec.rs2 = inst[24:20];

		case (inst[6:0])
			exec_pkg::op_lui,
			exec_pkg::op_auipc: begin
				dec.imm = imm_u;
			end
			exec_pkg::op_jal: begin
				dec.imm = imm_j;
			end
			exec_pkg::op_jalr,
			exec_pkg::op_load,
			exec_pkg::op_imm,
			exec_pkg::op_imm_32: begin
				dec.imm = imm_i; // shamt sits in the low bits
			end
			exec_pkg::op_store: begin
				dec.imm = imm_s;
			end
			exec_pkg::op_branch: begin
				dec.imm = imm_b;
			end
			default: begin
				dec.imm = '0; // register ops and anything unsupported
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== regfile.sv ====
// integer register file, 31 writable registers, two combinational reads, x0 hardwired to zero
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input wire clk,
	input wire rst_n,
	input wire [4:0] rs1,
	input wire [4:0] rs2,
	input wire wen,
	input wire [4:0] rd,
	input wire [exec_pkg::xlen-1:0] wdata,
	output logic [exec_pkg::xlen-1:0] src1,
	output logic [exec_pkg::xlen-1:0] src2
);

	logic [exec_pkg::xlen-1:0] regs [1:31]; // no storage for x0

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	assign src1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign src2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== alu.sv ====
// 64-bit alu for the base integer ops, word mode works on the low half and sign-extends
`timescale 1ns/1ps
`default_nettype none

module alu (
	input wire exec_pkg::alu_sel_t sel,
	input wire [exec_pkg::xlen-1:0] a,
	input wire [exec_pkg::xlen-1:0] b,
	input wire sub_sra,
	input wire is_word,
	output logic [exec_pkg::xlen-1:0] result,
	output exec_pkg::alu_flags_t flags
);

	logic [exec_pkg::xlen-1:0] b_eff;
	logic [exec_pkg::xlen-1:0] sum;
	logic [5:0] shamt;
	logic [exec_pkg::xlen-1:0] sh_src;
	logic [exec_pkg::xlen:0] shr_ext;
	logic [exec_pkg::xlen-1:0] raw;

	assign b_eff = sub_sra ? ~b : b;
	assign sum = a + b_eff + {{(exec_pkg::xlen-1){1'b0}}, sub_sra}; // two's complement sub

	assign shamt = is_word ? {1'b0, b[4:0]} : b[5:0];

	// word sra needs bit 31 copied up before shifting right
	assign sh_src = is_word ? {{32{sub_sra & a[31]}}, a[31:0]} : a;
	assign shr_ext = $signed({sub_sra & sh_src[exec_pkg::xlen-1], sh_src}) >>> shamt;

	// full width compare, branches and slt share it
	assign flags.equal = (a == b);
	assign flags.smaller_s = ($signed(a) < $signed(b));
	assign flags.smaller_u = (a < b);

	always_comb begin
		case (sel)
			exec_pkg::alu_add: raw = sum;
			exec_pkg::alu_sll: raw = a << shamt;
			exec_pkg::alu_slt: raw = {{(exec_pkg::xlen-1){1'b0}}, flags.smaller_s};
			exec_pkg::alu_sltu: raw = {{(exec_pkg::xlen-1){1'b0}}, flags.smaller_u};
			exec_pkg::alu_xor: raw = a ^ b;
			exec_pkg::alu_srl: raw = shr_ext[exec_pkg::xlen-1:0]; // logical or arithmetic
			exec_pkg::alu_or: raw = a | b;
			exec_pkg::alu_and: raw = a & b;
			default: raw = '0;
		endcase
	end

	assign result = is_word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

// ==== exu.sv ====
// execution unit, picks alu operands per opcode, resolves branches, forms next pc and rd data
`timescale 1ns/1ps
`default_nettype none

module exu (
	input wire exec_pkg::decoded_t dec,
	input wire [exec_pkg::xlen-1:0] src1,
	input wire [exec_pkg::xlen-1:0] src2,
	input wire [exec_pkg::xlen-1:0] pc,
	input wire [exec_pkg::xlen-1:0] ld_data,
	output logic [exec_pkg::xlen-1:0] alu_a,
	output logic [exec_pkg::xlen-1:0] alu_b,
	output exec_pkg::alu_sel_t alu_sel,
	output logic sub_sra,
	output logic is_word,
	output exec_pkg::commit_t commit,
	input wire [exec_pkg::xlen-1:0] alu_result,
	input wire exec_pkg::alu_flags_t flags
);

	logic branch_con;
	logic [exec_pkg::xlen-1:0] dnpc_base;
	logic [exec_pkg::xlen-1:0] dnpc_offs;
	logic [exec_pkg::xlen-1:0] dnpc_sum;
	logic is_jalr;

	assign is_jalr = (dec.opcode == exec_pkg::op_jalr);
	assign is_word = (dec.opcode == exec_pkg::op_imm_32) || (dec.opcode == exec_pkg::op_reg_32);

	always_comb begin
		alu_sel = exec_pkg::alu_add;
		alu_a = '0;
		alu_b = '0;
		sub_sra = 1'b0;
		commit.rd_wen = 1'b1;
		commit.rd = dec.rd;
		commit.x_rd = alu_result;
		commit.dnpc = is_jalr ? {dnpc_sum[exec_pkg::xlen-1:1], 1'b0} : dnpc_sum;
		case (dec.opcode)
			exec_pkg::op_lui: begin
				commit.x_rd = dec.imm;
			end
			exec_pkg::op_auipc: begin
				alu_a = pc;
				alu_b = dec.imm;
			end
			exec_pkg::op_jal,
			exec_pkg::op_jalr: begin
				alu_a = pc; // link address pc + 4
				alu_b = 64'd4;
			end
			exec_pkg::op_branch: begin
				alu_a = src1;
				alu_b = src2;
				commit.rd_wen = 1'b0;
				commit.x_rd = '0;
			end
			exec_pkg::op_load,
			exec_pkg::op_store: begin
				alu_a = src1; // effective address
				alu_b = dec.imm;
				commit.rd_wen = (dec.opcode == exec_pkg::op_load);
				commit.x_rd = (dec.opcode == exec_pkg::op_load) ? ld_data : '0;
			end
			exec_pkg::op_imm: begin
				alu_sel = dec.funct3;
				alu_a = src1;
				alu_b = dec.imm;
				sub_sra = (dec.funct3 == exec_pkg::alu_srl) & dec.alt; // imm bit 10 otherwise
			end
			exec_pkg::op_reg: begin
				alu_sel = dec.funct3;
				alu_a = src1;
				alu_b = src2;
				sub_sra = dec.alt;
			end
			exec_pkg::op_imm_32: begin
				alu_sel = dec.funct3;
				alu_a = {32'b0, src1[31:0]};
				alu_b = {32'b0, dec.imm[31:0]};
				sub_sra = (dec.funct3 == exec_pkg::alu_srl) & dec.alt;
			end
			exec_pkg::op_reg_32: begin
				alu_sel = dec.funct3;
				alu_a = {32'b0, src1[31:0]};
				alu_b = {32'b0, src2[31:0]};
				sub_sra = dec.alt;
			end
			default: begin
				commit.rd_wen = 1'b0; // fence, system and the rest retire as no-ops
				commit.x_rd = '0;
			end
		endcase
	end

	always_comb begin
		case (dec.funct3)
			exec_pkg::f3_beq: branch_con = flags.equal;
			exec_pkg::f3_bne: branch_con = ~flags.equal;
			exec_pkg::f3_blt: branch_con = flags.smaller_s;
			exec_pkg::f3_bge: branch_con = ~flags.smaller_s;
			exec_pkg::f3_bltu: branch_con = flags.smaller_u;
			exec_pkg::f3_bgeu: branch_con = ~flags.smaller_u;
			default: branch_con = 1'b0;
		endcase
	end

	assign dnpc_base = is_jalr ? src1 : pc;

	always_comb begin
		if (dec.opcode == exec_pkg::op_jal || is_jalr) begin
			dnpc_offs = dec.imm;
		end else if (dec.opcode == exec_pkg::op_branch && branch_con) begin
			dnpc_offs = dec.imm;
		end else begin
			dnpc_offs = 64'd4;
		end
	end

	assign dnpc_sum = dnpc_base + dnpc_offs;

endmodule

`default_nettype wire

// ==== mau.sv ====
// memory access unit, small doubleword data ram with byte-masked stores and extending loads
`timescale 1ns/1ps
`default_nettype none

module mau (
	input wire clk,
	input wire rst_n,
	input wire inst_valid,
	input wire exec_pkg::decoded_t dec,
	input wire [exec_pkg::xlen-1:0] addr,
	input wire [exec_pkg::xlen-1:0] src2,
	output logic [exec_pkg::xlen-1:0] ld_data
);

	logic [exec_pkg::xlen-1:0] mem [exec_pkg::dmem_words];
	logic [exec_pkg::dmem_aw-1:0] idx;
	logic [2:0] boff; // byte offset in the doubleword
	logic [7:0] be;
	logic [exec_pkg::xlen-1:0] wdat;
	logic [exec_pkg::xlen-1:0] rd_shift;

	assign idx = addr[exec_pkg::dmem_aw+2:3];
	assign boff = addr[2:0];
	assign wdat = src2 << {boff, 3'b000};

	always_comb begin
		case (dec.funct3)
			exec_pkg::f3_byte: be = 8'h01 << boff;
			exec_pkg::f3_half: be = 8'h03 << boff;
			exec_pkg::f3_word: be = 8'h0f << boff;
			exec_pkg::f3_dword: be = 8'hff;
			default: be = 8'h00;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < exec_pkg::dmem_words; i++) begin
				mem[i] <= '0;
			end
		end else if (inst_valid && dec.opcode == exec_pkg::op_store) begin
			for (int b = 0; b < 8; b++) begin
				if (be[b]) mem[idx][b*8 +: 8] <= wdat[b*8 +: 8];
			end
		end
	end

	assign rd_shift = mem[idx] >> {boff, 3'b000};

	always_comb begin
		case (dec.funct3)
			exec_pkg::f3_byte: ld_data = {{56{rd_shift[7]}}, rd_shift[7:0]};
			exec_pkg::f3_half: ld_data = {{48{rd_shift[15]}}, rd_shift[15:0]};
			exec_pkg::f3_word: ld_data = {{32{rd_shift[31]}}, rd_shift[31:0]};
			exec_pkg::f3_dword: ld_data = rd_shift;
			exec_pkg::f3_bu: ld_data = {56'b0, rd_shift[7:0]};
			exec_pkg::f3_hu: ld_data = {48'b0, rd_shift[15:0]};
			exec_pkg::f3_wu: ld_data = {32'b0, rd_shift[31:0]};
			default: ld_data = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== exec_core.sv ====
// top level of the execute subsystem, holds the pc and retires one instruction per strobe
`timescale 1ns/1ps
`default_nettype none

module exec_core (
	input wire clk,
	input wire rst_n,
	input wire inst_valid,
	input wire [31:0] inst,
	output logic [exec_pkg::xlen-1:0] pc,
	output logic retire,
	output exec_pkg::commit_t commit
);

	exec_pkg::decoded_t dec;
	logic [exec_pkg::xlen-1:0] src1;
	logic [exec_pkg::xlen-1:0] src2;
	logic [exec_pkg::xlen-1:0] alu_a;
	logic [exec_pkg::xlen-1:0] alu_b;
	exec_pkg::alu_sel_t alu_sel;
	logic sub_sra;
	logic is_word;
	logic [exec_pkg::xlen-1:0] alu_result;
	exec_pkg::alu_flags_t flags;
	logic [exec_pkg::xlen-1:0] ld_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= exec_pkg::reset_pc;
		end else if (inst_valid) begin
			pc <= commit.dnpc;
		end
	end

	assign retire = inst_valid;

	idu u_idu (.inst(inst), .dec(dec));

	regfile u_regfile (
		.clk(clk), .rst_n(rst_n),
		.rs1(dec.rs1), .rs2(dec.rs2),
		.wen(commit.rd_wen & inst_valid), // only on a real retire
		.rd(commit.rd), .wdata(commit.x_rd),
		.src1(src1), .src2(src2)
	);

	exu u_exu (
		.dec(dec), .src1(src1), .src2(src2), .pc(pc), .ld_data(ld_data),
		.alu_a(alu_a), .alu_b(alu_b), .alu_sel(alu_sel),
		.sub_sra(sub_sra), .is_word(is_word), .commit(commit),
		.alu_result(alu_result), .flags(flags)
	);

	alu u_alu (
		.sel(alu_sel), .a(alu_a), .b(alu_b), .sub_sra(sub_sra), .is_word(is_word),
		.result(alu_result), .flags(flags)
	);

	mau u_mau (
		.clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .dec(dec),
		.addr(alu_result), .src2(src2), .ld_data(ld_data)
	);

endmodule

`default_nettype wire

// ==== tb_exec_core.sv ====
// random-instruction testbench for exec_core, checks each retire against an isa reference model
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

	localparam int num_cycles = 3000;
	localparam int timeout_ns = (num_cycles + 20) * 40; // issue cycles plus margin

	logic clk = 1'b0;
	logic rst_n;
	logic inst_valid;
	logic [31:0] inst;
	logic [63:0] pc;
	logic retire;
	exec_pkg::commit_t commit;

	// reference model state
	logic [63:0] xreg [32];
	logic [7:0] dmem [512];
	logic [63:0] mpc;
	logic exp_wen;
	logic [63:0] exp_val;
	logic [63:0] exp_dnpc;

	// fields of the instruction on the bus
	logic [6:0] opc;
	logic [2:0] f3;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic alt;
	logic [63:0] imm;

	int errors = 0;
	int checks = 0;
	int seed;

	exec_core dut0 (
		.clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst),
		.pc(pc), .retire(retire), .commit(commit)
	);

	always #20 clk = ~clk;

	task automatic check_value(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s inst %h expected %h actual %h", what, inst, expected, actual);
		end
	endtask

	// picks a legal instruction, keeps its fields and drives the encoding
	task automatic issue_random_inst();
		int sel;
		int off;
		logic [11:0] r12;
		logic [19:0] r20;
		sel = $urandom % 12;
		rd = $urandom % 16;
		rs1 = $urandom % 16; // small register set for more reuse
		rs2 = $urandom % 16;
		f3 = $urandom;
		r12 = $urandom;
		r20 = $urandom;
		alt = 1'b0;
		imm = {{52{r12[11]}}, r12};
		off = $urandom % 512;
		case (sel)
			0: opc = exec_pkg::op_reg;
			1: opc = exec_pkg::op_imm;
			2: opc = exec_pkg::op_reg_32;
			3: opc = exec_pkg::op_imm_32;
			4: opc = exec_pkg::op_lui;
			5: opc = exec_pkg::op_auipc;
			6: opc = exec_pkg::op_jal;
			7: opc = exec_pkg::op_jalr;
			8: opc = exec_pkg::op_branch;
			9: opc = exec_pkg::op_store;
			10: opc = exec_pkg::op_load;
			default: opc = ($urandom % 2) ? 7'b0001111 : 7'b1110011; // fence or system
		endcase
		if (sel == 2 || sel == 3) begin
			f3 = ($urandom % 3 == 0) ? 3'd0 : (($urandom % 2) ? 3'd1 : 3'd5); // word forms
		end
		if (sel <= 3 && (f3 == 3'd0 || f3 == 3'd5)) begin
			alt = $urandom;
		end
		if ((sel == 1 || sel == 3) && f3 == 3'd0) begin
			alt = 1'b0; // no subi or subiw
		end
		if ((sel == 1 || sel == 3) && (f3 == 3'd1 || f3 == 3'd5)) begin
			imm = {53'd0, alt, 4'd0, (sel == 3) ? {1'b0, r12[4:0]} : r12[5:0]};
		end
		if (sel == 4 || sel == 5) begin
			imm = {{32{r20[19]}}, r20, 12'd0};
		end
		if (sel == 6) begin
			imm = {{43{r20[19]}}, r20, 1'b0};
		end
		if (sel == 7) begin
			f3 = 3'd0;
		end
		if (sel == 8) begin
			f3 = $urandom % 6;
			f3 = (f3 >= 3'd2) ? f3 + 3'd2 : f3; // skip the two unused codes
			imm = {{51{r12[11]}}, r12, 1'b0};
		end
		if (sel == 9 || sel == 10) begin
			f3 = (sel == 9) ? $urandom % 4 : $urandom % 7;
			rs1 = 5'd0;
			imm = off & ~((1 << f3[1:0]) - 1); // aligned to the access size
		end
		case (opc)
			exec_pkg::op_reg, exec_pkg::op_reg_32: inst = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, opc};
			exec_pkg::op_imm, exec_pkg::op_imm_32, exec_pkg::op_jalr, exec_pkg::op_load: begin
				inst = {imm[11:0], rs1, f3, rd, opc};
			end
			exec_pkg::op_store: inst = {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
			exec_pkg::op_branch: begin
				inst = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
			end
			exec_pkg::op_lui, exec_pkg::op_auipc: inst = {imm[31:12], rd, opc};
			exec_pkg::op_jal: inst = {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
			default: inst = {25'($urandom), opc};
		endcase
	endtask

	// isa reference, works from the fields and the model state
	task automatic model_exec();
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] opnd;
		logic [31:0] r32;
		logic taken;
		int addr;
		int nb;
		a = xreg[rs1];
		b = xreg[rs2];
		opnd = (opc == exec_pkg::op_reg || opc == exec_pkg::op_reg_32) ? b : imm;
		exp_wen = 1'b1;
		exp_val = 64'd0;
		exp_dnpc = mpc + 64'd4;
		case (opc)
			exec_pkg::op_reg, exec_pkg::op_imm: begin
				case (f3)
					3'd0: exp_val = alt ? a - opnd : a + opnd;
					3'd1: exp_val = a << opnd[5:0];
					3'd2: exp_val = {63'd0, $signed(a) < $signed(opnd)};
					3'd3: exp_val = {63'd0, a < opnd};
					3'd4: exp_val = a ^ opnd;
					3'd5: begin
						if (alt) exp_val = $signed(a) >>> opnd[5:0];
						else exp_val = a >> opnd[5:0];
					end
					3'd6: exp_val = a | opnd;
					default: exp_val = a & opnd;
				endcase
			end
			exec_pkg::op_reg_32, exec_pkg::op_imm_32: begin
				case (f3)
					3'd0: r32 = alt ? a[31:0] - opnd[31:0] : a[31:0] + opnd[31:0];
					3'd1: r32 = a[31:0] << opnd[4:0];
					default: begin
						if (alt) r32 = $signed(a[31:0]) >>> opnd[4:0];
						else r32 = a[31:0] >> opnd[4:0];
					end
				endcase
				exp_val = {{32{r32[31]}}, r32};
			end
			exec_pkg::op_lui: exp_val = imm;
			exec_pkg::op_auipc: exp_val = mpc + imm;
			exec_pkg::op_jal: begin
				exp_val = mpc + 64'd4;
				exp_dnpc = mpc + imm;
			end
			exec_pkg::op_jalr: begin
				exp_val = mpc + 64'd4;
				exp_dnpc = (a + imm) & ~64'd1;
			end
			exec_pkg::op_branch: begin
				case (f3)
					3'd0: taken = (a == b);
					3'd1: taken = (a != b);
					3'd4: taken = ($signed(a) < $signed(b));
					3'd5: taken = ($signed(a) >= $signed(b));
					3'd6: taken = (a < b);
					default: taken = (a >= b);
				endcase
				exp_wen = 1'b0;
				if (taken) exp_dnpc = mpc + imm;
			end
			exec_pkg::op_load: begin
				addr = imm[8:0];
				nb = 1 << f3[1:0];
				for (int i = 0; i < nb; i++) exp_val[8*i +: 8] = dmem[addr + i];
				for (int i = 8 * nb; i < 64; i++) exp_val[i] = !f3[2] & exp_val[8*nb-1];
			end
			default: exp_wen = 1'b0; // stores and no-ops
		endcase
	endtask

	task automatic model_retire();
		int nb;
		nb = 1 << f3[1:0];
		if (opc == exec_pkg::op_store) begin
			for (int i = 0; i < nb; i++) dmem[int'(imm[8:0]) + i] = xreg[rs2][8*i +: 8];
		end
		if (exp_wen && rd != 5'd0) xreg[rd] = exp_val;
		mpc = exp_dnpc;
	endtask

	initial begin
		seed = $urandom(32'hf258);
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst = 32'd0;
		mpc = exec_pkg::reset_pc;
		for (int i = 0; i < 32; i++) xreg[i] = 64'd0;
		for (int i = 0; i < 512; i++) dmem[i] = 8'd0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_value("pc in reset", exec_pkg::reset_pc, pc);
		check_value("retire in reset", 64'd0, retire);
		@(posedge clk);
		#2 rst_n = 1'b1;
		for (int n = 0; n < num_cycles; n++) begin
			@(posedge clk);
			#2;
			if ($urandom % 4 == 0) begin
				inst_valid = 1'b0;
				inst = $urandom; // junk while idle
			end else begin
				issue_random_inst();
				inst_valid = 1'b1;
			end
			@(negedge clk);
			check_value("pc", mpc, pc);
			check_value("retire", inst_valid, retire);
			if (inst_valid) begin
				model_exec();
				check_value("rd_wen", exp_wen, commit.rd_wen);
				if (exp_wen) begin
					check_value("rd", rd, commit.rd);
					check_value("x_rd", exp_val, commit.x_rd);
				end
				check_value("dnpc", exp_dnpc, commit.dnpc);
				model_retire();
			end
		end
		@(posedge clk);
		#2 inst_valid = 1'b0;
		@(negedge clk);
		check_value("final pc", mpc, pc);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(timeout_ns);
		$display("timeout, the instruction loop did not finish within %0d ns", timeout_ns);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
exec_pkg.sv
idu.sv
regfile.sv
alu.sv
exu.sv
mau.sv
exec_core.sv
tb_exec_core.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - files:
      - exec_pkg.sv
      - idu.sv
      - regfile.sv
      - alu.sv
      - exu.sv
      - mau.sv
      - exec_core.sv
  - target: simulation
    files:
      - tb_exec_core.sv
